/* ks10_defines.svh */
// Bus width, control ROM field, dispatch ROM field and PC flag bit position macros
`ifndef KS10_DEFINES_SVH
`define KS10_DEFINES_SVH

// Bus widths
`define CROM_WIDTH 28
`define DROM_WIDTH 12
`define DP_WIDTH   36
`define VMA_WIDTH  22
`define FLAG_WIDTH 14

// First data path bit of the address, bit 0 is the MSB
`define VMA_FIRST  (`DP_WIDTH - `VMA_WIDTH)

// Control ROM memory fields, bit 0 is the MSB, bits 19 to 27 unused here
`define CROM_MEM_CYCLE       0
`define CROM_MEM_LOADVMA     1
`define CROM_MEM_AREAD       2
`define CROM_MEM_DPFUNC      3
`define CROM_MEM_WAIT        4
`define CROM_MEM_BWRITE      5
`define CROM_MEM_EXTADDR     6
`define CROM_MEM_FORCEEXEC   7
`define CROM_MEM_FORCEUSER   8
`define CROM_MEM_FETCHCYCLE  9
`define CROM_MEM_PHYSICAL    10
`define CROM_MEM_READCYCLE   11
`define CROM_MEM_WRTESTCYCLE 12
`define CROM_MEM_WRITECYCLE  13
`define CROM_MEM_CACHEINH    14
`define CROM_SPEC_EN         15
`define CROM_SPEC_SEL_FIRST  16
`define CROM_SPEC_SEL_LAST   18

// Dispatch ROM fields
`define DROM_READCYCLE   0
`define DROM_WRTESTCYCLE 1
`define DROM_WRITECYCLE  2
`define DROM_COND_FUNC   7
`define DROM_VMA         8

// PC flag bits
`define PCFLAG_USER 5
`define PCFLAG_PCU  6

`endif

/* ks10_pkg.sv */
// VMA flag struct, special function select enum and APB state enum
`default_nettype none

package ks10_pkg;

   //////////////////////////////////////////////////
   // VMA flags
   //////////////////////////////////////////////////

   // First member lands on flag bit 0, the MSB
   typedef struct packed {
      logic user;
      logic spare1;
      logic fetch;
      logic read;
      logic wrTest;
      logic write;
      logic spare6;
      logic cacheInh;
      logic physical;
      // Previous context reference
      logic previous;
      logic io;
      // Write to user space from exec
      logic wrUser;
      logic vector;
      logic ioByte;
   } vmaFlags_t;

   //////////////////////////////////////////////////
   // Special function select
   //////////////////////////////////////////////////

   // Only CLRCACHE and PREVIOUS matter to the memory stage
   typedef enum logic [2:0] {
      NOSPEC   = 3'd0,
      INHCRY18 = 3'd1,
      LOADAPR  = 3'd2,
      LOADPI   = 3'd3,
      PREVIOUS = 3'd4,
      IOCLR    = 3'd5,
      MEMCLR   = 3'd6,
      CLRCACHE = 3'd7
   } specSel_t;

   // Bus master phases
   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      SETUP  = 2'd1,
      ACCESS = 2'd2
   } apbState_t;

endpackage

`default_nettype wire

/* memCtrlIf.sv */
// Memory-control strobe bundle with decoder and VMA register modports
`default_nettype none

interface memCtrlIf;
   // Load enables and source selects
   logic vmaEn;
   logic memEn;
   logic dpFunc;
   logic aread;
   logic selPrevious;
   // Control ROM fields
   logic forceExec;
   logic forceUser;
   logic fetchCycle;
   logic physical;
   logic extAddr;
   logic readCycle;
   logic wrTestCycle;
   logic writeCycle;
   logic cacheInh;
   // Dispatch ROM cycle type
   logic dromRead;
   logic dromWrTest;
   logic dromWrite;

   modport decoder (output vmaEn, memEn, dpFunc, aread, selPrevious, forceExec, forceUser,
                    fetchCycle, physical, extAddr, readCycle, wrTestCycle, writeCycle,
                    cacheInh, dromRead, dromWrTest, dromWrite);
   modport vma (input vmaEn, memEn, dpFunc, aread, selPrevious, forceExec, forceUser,
                fetchCycle, physical, extAddr, readCycle, wrTestCycle, writeCycle,
                cacheInh, dromRead, dromWrTest, dromWrite);
endinterface

`default_nettype wire

/* microMemDecode.sv */
// Control ROM and dispatch ROM decode into memory-control strobes
`default_nettype none
`include "ks10_defines.svh"

module microMemDecode
(
   input  wire [0:`CROM_WIDTH-1] crom,
   input  wire [0:`DROM_WIDTH-1] drom,
   memCtrlIf.decoder             ctrl
);
   import ks10_pkg::*;

   specSel_t specSel;
   logic     memCycle;
   logic     cacheSweep;
   logic     selPrevious;

   //////////////////////////////////////////////////
   // Special function
   //////////////////////////////////////////////////

   assign specSel     = specSel_t'(crom[`CROM_SPEC_SEL_FIRST:`CROM_SPEC_SEL_LAST]);
   assign memCycle    = crom[`CROM_MEM_CYCLE];
   // Sweep only reloads the address
   assign cacheSweep  = crom[`CROM_SPEC_EN] && (specSel == CLRCACHE);
   assign selPrevious = crom[`CROM_SPEC_EN] && (specSel == PREVIOUS);

   //////////////////////////////////////////////////
   // Load enables
   //////////////////////////////////////////////////

   // Address load, direct or dispatch qualified
   assign ctrl.vmaEn = (memCycle && crom[`CROM_MEM_LOADVMA]) ||
                       (memCycle && crom[`CROM_MEM_AREAD] && drom[`DROM_VMA]) ||
                       cacheSweep;

   // Cycle control load, wait or conditional byte write
   assign ctrl.memEn = (memCycle && crom[`CROM_MEM_WAIT]) ||
                       (memCycle && crom[`CROM_MEM_BWRITE] && drom[`DROM_COND_FUNC]);

   assign ctrl.dpFunc      = crom[`CROM_MEM_DPFUNC];
   assign ctrl.aread       = crom[`CROM_MEM_AREAD];
   assign ctrl.selPrevious = selPrevious;

   // Straight field copies
   assign ctrl.forceExec   = crom[`CROM_MEM_FORCEEXEC];
   assign ctrl.forceUser   = crom[`CROM_MEM_FORCEUSER];
   assign ctrl.fetchCycle  = crom[`CROM_MEM_FETCHCYCLE];
   assign ctrl.physical    = crom[`CROM_MEM_PHYSICAL];
   assign ctrl.extAddr     = crom[`CROM_MEM_EXTADDR];
   assign ctrl.readCycle   = crom[`CROM_MEM_READCYCLE];
   assign ctrl.wrTestCycle = crom[`CROM_MEM_WRTESTCYCLE];
   assign ctrl.writeCycle  = crom[`CROM_MEM_WRITECYCLE];
   assign ctrl.cacheInh    = crom[`CROM_MEM_CACHEINH];

   // Cycle type from the dispatch ROM
   assign ctrl.dromRead    = drom[`DROM_READCYCLE];
   assign ctrl.dromWrTest  = drom[`DROM_WRTESTCYCLE];
   assign ctrl.dromWrite   = drom[`DROM_WRITECYCLE];

endmodule

`default_nettype wire

/* vmaRegister.sv */
// VMA address register, flag register, cycle-control register and cycle-start pulse
`default_nettype none
`include "ks10_defines.svh"

module vmaRegister
(
   input  wire                             clk,
   input  wire                             rst,
   input  wire                             clken,
   input  wire [0:`DP_WIDTH-1]             dp,
   input  wire                             cpuExec,
   input  wire                             prevEn,
   input  wire [0:17]                      pcFlags,
   memCtrlIf.vma                           ctrl,
   output logic [`VMA_FIRST:`DP_WIDTH-1]   vmaAddr,
   output logic                            vmaExtended,
   output ks10_pkg::vmaFlags_t             vmaFlags,
   output logic [0:`DP_WIDTH-1]            wdata,
   output logic                            cycleStart
);
   import ks10_pkg::*;

   vmaFlags_t dpFlags;
   logic      pcUser;
   logic      pcPrevUser;
   logic      userNext;
   logic      readNext;
   logic      wrTestNext;
   logic      writeNext;
   logic      cacheInhNext;

   // Flag field of dp lines up with the flag struct
   assign dpFlags    = vmaFlags_t'(dp[0:`FLAG_WIDTH-1]);
   assign pcUser     = pcFlags[`PCFLAG_USER];
   assign pcPrevUser = pcFlags[`PCFLAG_PCU];

   //////////////////////////////////////////////////
   // User flag from PC flags and microcode
   //////////////////////////////////////////////////

   // Exec forcing, fetch, previous context or forced user
   assign userNext = (!ctrl.forceExec && pcUser && !cpuExec) ||
                     (ctrl.fetchCycle && pcUser) ||
                     (prevEn && pcPrevUser) ||
                     (ctrl.selPrevious && pcPrevUser) ||
                     ctrl.forceUser;

   // Cycle type source, dispatch ROM first, then dp, then control ROM
   always_comb
   begin
      if (ctrl.aread)
      begin
         readNext     = ctrl.dromRead;
         wrTestNext   = ctrl.dromWrTest;
         writeNext    = ctrl.dromWrite;
         cacheInhNext = 1'b0;
      end
      else if (ctrl.dpFunc)
      begin
         readNext     = dpFlags.read;
         wrTestNext   = dpFlags.wrTest;
         writeNext    = dpFlags.write;
         cacheInhNext = dpFlags.cacheInh;
      end
      else
      begin
         readNext     = ctrl.readCycle;
         wrTestNext   = ctrl.wrTestCycle;
         writeNext    = ctrl.writeCycle;
         cacheInhNext = ctrl.cacheInh;
      end
   end

   //////////////////////////////////////////////////
   // Registers
   //////////////////////////////////////////////////

   // Spare flags are only ever written by reset
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         vmaAddr     <= '0;
         vmaExtended <= 1'b0;
         vmaFlags    <= '0;
         wdata       <= '0;
         cycleStart  <= 1'b0;
      end
      else
      begin
         cycleStart <= 1'b0;
         // Address and context flags
         if (clken && ctrl.vmaEn)
         begin
            vmaAddr     <= dp[`VMA_FIRST:`DP_WIDTH-1];
            vmaExtended <= ctrl.extAddr;
            if (ctrl.dpFunc)
            begin
               vmaFlags.user     <= dpFlags.user;
               vmaFlags.fetch    <= dpFlags.fetch;
               vmaFlags.physical <= dpFlags.physical;
               vmaFlags.previous <= dpFlags.previous;
               vmaFlags.io       <= dpFlags.io;
               vmaFlags.wrUser   <= dpFlags.wrUser;
               vmaFlags.vector   <= dpFlags.vector;
               vmaFlags.ioByte   <= dpFlags.ioByte;
            end
            else
            begin
               vmaFlags.user     <= userNext;
               vmaFlags.fetch    <= ctrl.fetchCycle;
               vmaFlags.physical <= ctrl.physical;
               vmaFlags.previous <= prevEn || ctrl.selPrevious;
               vmaFlags.io       <= 1'b0;
               vmaFlags.wrUser   <= 1'b0;
               vmaFlags.vector   <= 1'b0;
               vmaFlags.ioByte   <= 1'b0;
            end
         end
         // Cycle control, start only for a read or write
         if (clken && ctrl.memEn)
         begin
            vmaFlags.read     <= readNext;
            vmaFlags.wrTest   <= wrTestNext;
            vmaFlags.write    <= writeNext;
            vmaFlags.cacheInh <= cacheInhNext;
            wdata             <= dp;
            cycleStart        <= readNext || writeNext;
         end
      end
   end

endmodule

`default_nettype wire

/* apbMemMaster.sv */
// APB master that runs one transfer per started memory cycle
`default_nettype none
`include "ks10_defines.svh"

module apbMemMaster
(
   input  wire                             clk,
   input  wire                             rst,
   input  wire                             cycleStart,
   input  wire [`VMA_FIRST:`DP_WIDTH-1]    vmaAddr,
   input  wire ks10_pkg::vmaFlags_t        vmaFlags,
   input  wire [0:`DP_WIDTH-1]             wdata,
   input  wire [`DP_WIDTH-1:0]             prdata,
   input  wire                             pready,
   output logic [`VMA_WIDTH-1:0]           paddr,
   output logic                            psel,
   output logic                            penable,
   output logic                            pwrite,
   output logic [`DP_WIDTH-1:0]            pwdata,
   output logic                            memWait,
   output logic [0:`DP_WIDTH-1]            rdata,
   output logic                            rdataValid
);
   import ks10_pkg::*;

   apbState_t state;
   logic      startXfer;

   // Neither read nor write means no transfer
   assign startXfer = cycleStart && (vmaFlags.read || vmaFlags.write);

   //////////////////////////////////////////////////
   // Transfer FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state      <= IDLE;
         paddr      <= '0;
         pwrite     <= 1'b0;
         pwdata     <= '0;
         memWait    <= 1'b0;
         rdata      <= '0;
         rdataValid <= 1'b0;
      end
      else
      begin
         rdataValid <= 1'b0;
         case (state)
            IDLE:
            begin
               // Latch address, direction and data for the whole transfer
               if (startXfer)
               begin
                  paddr   <= vmaAddr;
                  pwrite  <= !vmaFlags.read;
                  pwdata  <= wdata;
                  memWait <= 1'b1;
                  state   <= SETUP;
               end
            end
            SETUP:
            begin
               state <= ACCESS;
            end
            ACCESS:
            begin
               // Slave stretches ACCESS with pready low
               if (pready)
               begin
                  state   <= IDLE;
                  memWait <= 1'b0;
                  if (!pwrite)
                  begin
                     rdata      <= prdata;
                     rdataValid <= 1'b1;
                  end
               end
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   assign psel    = (state != IDLE);
   assign penable = (state == ACCESS);

   // Bus stays put across the transfer
   holdDuringXfer: assert property (@(posedge clk) disable iff (rst)
      psel && $past(psel) |-> $stable(paddr) && $stable(pwrite) && $stable(pwdata));
   // Next cycle load waits for the running transfer
   noStartWhileWait: assert property (@(posedge clk) disable iff (rst)
      cycleStart |-> !memWait);

endmodule

`default_nettype wire

/* vmaTop.sv */
// Memory address stage top level with decoder, VMA register and APB master
`default_nettype none
`include "ks10_defines.svh"

module vmaTop
(
   input  wire                             clk,
   input  wire                             rst,
   input  wire                             clken,
   input  wire [0:`CROM_WIDTH-1]           crom,
   input  wire [0:`DROM_WIDTH-1]           drom,
   input  wire [0:`DP_WIDTH-1]             dp,
   input  wire                             cpuExec,
   input  wire                             prevEn,
   input  wire [0:17]                      pcFlags,
   output wire [`VMA_FIRST:`DP_WIDTH-1]    vmaAddr,
   output wire                             vmaExtended,
   output wire ks10_pkg::vmaFlags_t        vmaFlags,
   output wire                             memWait,
   output wire [0:`DP_WIDTH-1]             rdata,
   output wire                             rdataValid,
   // APB master
   output wire [`VMA_WIDTH-1:0]            paddr,
   output wire                             psel,
   output wire                             penable,
   output wire                             pwrite,
   output wire [`DP_WIDTH-1:0]             pwdata,
   input  wire [`DP_WIDTH-1:0]             prdata,
   input  wire                             pready
);

   wire                 cycleStart;
   wire [0:`DP_WIDTH-1] wdata;

   // Decoded strobes, decoder to register
   memCtrlIf ctrlBus ();

   microMemDecode uDecode (.crom(crom), .drom(drom), .ctrl(ctrlBus.decoder));

   vmaRegister uVma (.clk(clk), .rst(rst), .clken(clken), .dp(dp), .cpuExec(cpuExec),
                     .prevEn(prevEn), .pcFlags(pcFlags), .ctrl(ctrlBus.vma),
                     .vmaAddr(vmaAddr), .vmaExtended(vmaExtended), .vmaFlags(vmaFlags),
                     .wdata(wdata), .cycleStart(cycleStart));

   apbMemMaster uApb (.clk(clk), .rst(rst), .cycleStart(cycleStart), .vmaAddr(vmaAddr),
                      .vmaFlags(vmaFlags), .wdata(wdata), .prdata(prdata), .pready(pready),
                      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
                      .pwdata(pwdata), .memWait(memWait), .rdata(rdata),
                      .rdataValid(rdataValid));

endmodule

`default_nettype wire

/* tb_vmaTop.sv */
// Testbench for vmaTop with clock, reset, stimulus tasks, APB responder and checks
`default_nettype none
`include "ks10_defines.svh"

module tb_vmaTop;
   import ks10_pkg::*;

   // Six tests at about 40 cycles each, plus margin
   localparam int MAX_CYCLES = 400;
   // Fields written by a VMA load, bit 0 is user
   localparam logic [0:`FLAG_WIDTH-1] CTX_FIELDS   = 14'b10100000111111;
   localparam logic [0:`FLAG_WIDTH-1] SPARE_FIELDS = 14'b01000010000000;

   logic                          clk = 1'b0;
   logic                          rst;
   logic                          clken;
   logic [0:`CROM_WIDTH-1]        crom;
   logic [0:`DROM_WIDTH-1]        drom;
   logic [0:`DP_WIDTH-1]          dp;
   logic                          cpuExec;
   logic                          prevEn;
   logic [0:17]                   pcFlags;
   logic [`VMA_FIRST:`DP_WIDTH-1] vmaAddr;
   logic                          vmaExtended;
   vmaFlags_t                     vmaFlags;
   logic                          memWait;
   logic [0:`DP_WIDTH-1]          rdata;
   logic                          rdataValid;
   logic [`VMA_WIDTH-1:0]         paddr;
   logic                          psel;
   logic                          penable;
   logic                          pwrite;
   logic [`DP_WIDTH-1:0]          pwdata;
   logic [`DP_WIDTH-1:0]          prdata;
   logic                          pready;

   int errors    = 0;
   int errStart  = 0;
   int passCount = 0;
   int failCount = 0;
   int cycles    = 0;
   int waitLeft  = 0;

   vmaTop dut_i (.*);

   always #4 clk = ~clk;

   //////////////////////////////////////////////////
   // Run limit and APB responder
   //////////////////////////////////////////////////

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
         $display("Something failed");
         $finish;
      end
   end

   // 0 to 3 wait states per transfer, pready set in ACCESS only
   always @(negedge clk)
   begin
      if (psel && !penable)
      begin
         waitLeft = $urandom % 4;
         prdata   = rand36();
         pready   = 1'b0;
      end
      else if (penable && waitLeft > 0)
      begin
         waitLeft--;
         pready = 1'b0;
      end
      else
         pready = penable;
   end

   //////////////////////////////////////////////////
   // Bus protocol checks
   //////////////////////////////////////////////////

   setupToAccess: assert property (@(posedge clk) disable iff (rst)
      psel && !penable |=> psel && penable)
      else countFailure("APB SETUP cycle was not followed by ACCESS");
   holdInAccess: assert property (@(posedge clk) disable iff (rst)
      penable && !pready |=> penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
      else countFailure("APB transfer changed or ended while pready was low");
   endOfXfer: assert property (@(posedge clk) disable iff (rst)
      penable && pready |=> !psel && !memWait)
      else countFailure("Transfer or memWait continued after pready");
   waitCoversXfer: assert property (@(posedge clk) disable iff (rst) psel |-> memWait)
      else countFailure("memWait was low during a transfer");
   readReturn: assert property (@(posedge clk) disable iff (rst)
      penable && pready && !pwrite |=> rdataValid)
      else countFailure("Read completed without rdataValid");
   validOnlyOnRead: assert property (@(posedge clk) disable iff (rst)
      rdataValid |-> $past(penable && pready && !pwrite))
      else countFailure("rdataValid rose without a completed read");

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic logic [`DP_WIDTH-1:0] rand36();
      logic [`DP_WIDTH-1:0] r;
      r[31:0]  = $urandom;
      r[35:32] = 4'($urandom);
      return r;
   endfunction

   task automatic countFailure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic checkValue(input string name, input logic [`DP_WIDTH-1:0] expVal,
                             input logic [`DP_WIDTH-1:0] actVal);
      assert (actVal === expVal)
      else
      begin
         errors++;
         $display("ERROR %s expected %h actual %h", name, expVal, actVal);
      end
   endtask

   task automatic endTest(input string name);
      if (errors == errStart)
      begin
         passCount++;
         $display("PASS %s", name);
      end
      else
      begin
         failCount++;
         $display("FAIL %s", name);
      end
      errStart = errors;
   endtask

   // Runs until memWait drops, read data due in that cycle
   task automatic waitXferDone(input bit isRead);
      int n;
      n = 0;
      while (memWait && n < 16)
      begin
         @(negedge clk);
         n++;
      end
      if (memWait)
      begin
         errors++;
         $display("Transfer did not end within 16 cycles");
      end
      else if (isRead)
      begin
         checkValue("rdataValid", 1, rdataValid);
         checkValue("rdata", prdata, rdata);
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////

   // Load without dpFunc, plain, previous select or cache sweep
   task automatic contextLoad();
      int                     kind;
      logic [0:4]             cf;
      logic [0:`DP_WIDTH-1]   d;
      logic                   userExp;
      logic [0:`FLAG_WIDTH-1] expFlags;
      logic [0:`FLAG_WIDTH-1] actFlags;
      kind = $urandom % 3;
      cf   = 5'($urandom);
      d    = rand36();
      crom = '0;
      crom[`CROM_MEM_CYCLE]   = (kind != 2);
      crom[`CROM_MEM_LOADVMA] = (kind != 2);
      crom[`CROM_SPEC_EN]     = (kind != 0);
      crom[`CROM_SPEC_SEL_FIRST:`CROM_SPEC_SEL_LAST] = (kind == 1) ? PREVIOUS : CLRCACHE;
      // forceExec, forceUser, fetch, physical, extAddr
      {crom[`CROM_MEM_FORCEEXEC], crom[`CROM_MEM_FORCEUSER], crom[`CROM_MEM_FETCHCYCLE],
       crom[`CROM_MEM_PHYSICAL], crom[`CROM_MEM_EXTADDR]} = cf;
      pcFlags = 18'($urandom);
      cpuExec = 1'($urandom);
      prevEn  = 1'($urandom);
      dp      = d;
      userExp = (!cf[0] && pcFlags[`PCFLAG_USER] && !cpuExec) ||
                (cf[2] && pcFlags[`PCFLAG_USER]) ||
                ((prevEn || kind == 1) && pcFlags[`PCFLAG_PCU]) || cf[1];
      expFlags    = '0;
      expFlags[0] = userExp;
      expFlags[2] = cf[2];
      expFlags[8] = cf[3];
      expFlags[9] = prevEn || (kind == 1);
      @(negedge clk);
      crom     = '0;
      actFlags = vmaFlags;
      checkValue("vmaAddr", d[`VMA_FIRST:`DP_WIDTH-1], vmaAddr);
      checkValue("vmaExtended", cf[4], vmaExtended);
      checkValue("vmaFlags", expFlags, actFlags & (CTX_FIELDS | SPARE_FIELDS));
   endtask

   task automatic dpFlagLoad();
      logic [0:`DP_WIDTH-1]   d;
      logic [0:`FLAG_WIDTH-1] actFlags;
      d    = rand36();
      crom = '0;
      crom[`CROM_MEM_CYCLE]   = 1'b1;
      crom[`CROM_MEM_LOADVMA] = 1'b1;
      crom[`CROM_MEM_DPFUNC]  = 1'b1;
      dp = d;
      @(negedge clk);
      crom     = '0;
      actFlags = vmaFlags;
      checkValue("vmaAddr", d[`VMA_FIRST:`DP_WIDTH-1], vmaAddr);
      // Each flag straight from its dp bit, spares stay zero
      checkValue("vmaFlags", d[0:`FLAG_WIDTH-1] & CTX_FIELDS,
                 actFlags & (CTX_FIELDS | SPARE_FIELDS));
   endtask

   // Mode 0 dispatch ROM, 1 dp, 2 control ROM, unused sources carry inverted bits
   task automatic cycleSource(input int mode, input bit noXfer);
      logic [0:3] r;
      logic [0:3] expBits;
      r = 4'($urandom);
      if (noXfer)
      begin
         r[0] = 1'b0;
         r[2] = 1'b0;
      end
      crom = '0;
      crom[`CROM_MEM_CYCLE] = 1'b1;
      crom[`CROM_MEM_WAIT]  = 1'b1;
      {crom[`CROM_MEM_READCYCLE], crom[`CROM_MEM_WRTESTCYCLE], crom[`CROM_MEM_WRITECYCLE],
       crom[`CROM_MEM_CACHEINH]} = ~r;
      drom = '0;
      {drom[`DROM_READCYCLE], drom[`DROM_WRTESTCYCLE], drom[`DROM_WRITECYCLE]} = ~r[0:2];
      dp = rand36();
      {dp[3], dp[4], dp[5], dp[7]} = ~r;
      case (mode)
         0:
         begin
            crom[`CROM_MEM_AREAD] = 1'b1;
            {drom[`DROM_READCYCLE], drom[`DROM_WRTESTCYCLE], drom[`DROM_WRITECYCLE]} = r[0:2];
         end
         1:
         begin
            crom[`CROM_MEM_DPFUNC] = 1'b1;
            {dp[3], dp[4], dp[5], dp[7]} = r;
         end
         default:
         begin
            {crom[`CROM_MEM_READCYCLE], crom[`CROM_MEM_WRTESTCYCLE],
             crom[`CROM_MEM_WRITECYCLE], crom[`CROM_MEM_CACHEINH]} = r;
         end
      endcase
      // Cache inhibit forced clear for a dispatch ROM cycle
      expBits = {r[0:2], (mode == 0) ? 1'b0 : r[3]};
      @(negedge clk);
      crom = '0;
      checkValue("vmaFlags.read/wrTest/write/cacheInh", expBits,
                 {vmaFlags.read, vmaFlags.wrTest, vmaFlags.write, vmaFlags.cacheInh});
      @(negedge clk);
      if (r[0] || r[2])
      begin
         checkValue("psel", 1, psel);
         waitXferDone(r[0]);
      end
      else
      begin
         repeat (3)
         begin
            checkValue("psel", 0, psel);
            @(negedge clk);
         end
      end
   endtask

   // Address and cycle loaded on one edge, SETUP in the cycle after cycleStart
   task automatic runTransfer(input bit isWrite);
      logic [0:`DP_WIDTH-1] d;
      d    = rand36();
      crom = '0;
      crom[`CROM_MEM_CYCLE]   = 1'b1;
      crom[`CROM_MEM_LOADVMA] = 1'b1;
      crom[`CROM_MEM_WAIT]    = 1'b1;
      if (isWrite)
         crom[`CROM_MEM_WRITECYCLE] = 1'b1;
      else
         crom[`CROM_MEM_READCYCLE] = 1'b1;
      dp = d;
      @(negedge clk);
      crom = '0;
      checkValue("psel", 0, psel);
      checkValue("memWait", 0, memWait);
      @(negedge clk);
      checkValue("psel", 1, psel);
      checkValue("penable", 0, penable);
      checkValue("pwrite", isWrite, pwrite);
      checkValue("paddr", d[`VMA_FIRST:`DP_WIDTH-1], paddr);
      checkValue("memWait", 1, memWait);
      if (isWrite)
         checkValue("pwdata", d, pwdata);
      waitXferDone(!isWrite);
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      void'($urandom(47));
      rst     = 1'b1;
      clken   = 1'b1;
      crom    = '0;
      drom    = '0;
      dp      = '0;
      cpuExec = 1'b0;
      prevEn  = 1'b0;
      pcFlags = '0;
      prdata  = '0;
      pready  = 1'b0;
      repeat (2) @(negedge clk);
      rst = 1'b0;

      checkValue("vmaAddr", 0, vmaAddr);
      checkValue("vmaFlags", 0, vmaFlags);
      checkValue("psel", 0, psel);
      checkValue("penable", 0, penable);
      checkValue("memWait", 0, memWait);
      checkValue("rdataValid", 0, rdataValid);
      endTest("reset state");

      repeat (8) contextLoad();
      endTest("VMA load from PC flags and microcode");
      repeat (4) dpFlagLoad();
      endTest("VMA load from dp");
      for (int mode = 0; mode < 3; mode++)
      begin
         cycleSource(mode, 1'b1);
         cycleSource(mode, 1'b0);
      end
      endTest("cycle control sources");
      repeat (3) runTransfer(1'b0);
      endTest("read cycle");
      repeat (3) runTransfer(1'b1);
      endTest("write cycle");

      $display("Tests passed %0d failed %0d", passCount, failCount);
      if (failCount == 0 && errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
ks10_pkg.sv
memCtrlIf.sv
microMemDecode.sv
vmaRegister.sv
apbMemMaster.sv
vmaTop.sv
tb_vmaTop.sv

/* Bender.yml */
package:
  name: vma_stage

sources:
  - include_dirs:
      - .
    files:
      - ks10_pkg.sv
      - memCtrlIf.sv
      - microMemDecode.sv
      - vmaRegister.sv
      - apbMemMaster.sv
      - vmaTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vmaTop.sv
